// File: common/exc_pkg.sv
package exc_pkg;

        ///////////////////////////////////////////////////////////////////////
        // Widths
        ///////////////////////////////////////////////////////////////////////
        localparam int word_w     = 32;
        localparam int exc_code_w = 5;
        localparam int int_lines  = 8;         // 0-1 software, 2-7 hardware

        ///////////////////////////////////////////////////////////////////////
        // Cause.ExcCode values
        ///////////////////////////////////////////////////////////////////////
        localparam logic [exc_code_w-1:0] exc_int  = 5'h00;
        localparam logic [exc_code_w-1:0] exc_adel = 5'h04;  // Load or fetch
        localparam logic [exc_code_w-1:0] exc_ades = 5'h05;  // Store
        localparam logic [exc_code_w-1:0] exc_sys  = 5'h08;
        localparam logic [exc_code_w-1:0] exc_bp   = 5'h09;
        localparam logic [exc_code_w-1:0] exc_ri   = 5'h0a;
        localparam logic [exc_code_w-1:0] exc_cpu  = 5'h0b;
        localparam logic [exc_code_w-1:0] exc_ov   = 5'h0c;

        // Boot exception vector, BEV=1
        localparam logic [word_w-1:0] exc_vector = 32'hbfc00380;

        ///////////////////////////////////////////////////////////////////////
        // CP0 register numbers
        ///////////////////////////////////////////////////////////////////////
        localparam logic [4:0] cp0_badvaddr = 5'd8;
        localparam logic [4:0] cp0_count    = 5'd9;
        localparam logic [4:0] cp0_compare  = 5'd11;
        localparam logic [4:0] cp0_status   = 5'd12;
        localparam logic [4:0] cp0_cause    = 5'd13;
        localparam logic [4:0] cp0_epc      = 5'd14;

        // BEV set, IM clear, EXL and IE clear
        localparam logic [word_w-1:0] status_reset = 32'h0040_0000;

endpackage

// File: cp0/cp0_regs.sv
`timescale 1ns/1ns
module cp0_regs (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            stall,
        input  logic                            mtc0_wen,
        input  logic [4:0]                      mtc0_addr,
        input  logic [exc_pkg::word_w-1:0]      mtc0_data,
        input  logic [4:0]                      mfc0_addr,
        input  logic                            exp_en,
        input  logic                            exl_clean,
        input  logic [exc_pkg::exc_code_w-1:0]  exp_code,
        input  logic                            exp_bd,
        input  logic [exc_pkg::word_w-1:0]      exp_epc,
        input  logic [exc_pkg::word_w-1:0]      bad_vaddr,
        input  logic                            bad_vaddr_wen,
        input  logic [5:0]                      ip_hw,

        output logic [exc_pkg::word_w-1:0]      mfc0_data,
        output logic [exc_pkg::word_w-1:0]      epc,
        output logic [exc_pkg::word_w-1:0]      status,
        output logic [1:0]                      cause_ip_sw,
        output logic                            timer_int
);

        logic                           cause_bd;
        logic [5:0]                     cause_ip_hw;
        logic [exc_pkg::exc_code_w-1:0] cause_code;
        logic [exc_pkg::word_w-1:0]     badvaddr;
        logic [exc_pkg::word_w-1:0]     count;
        logic [exc_pkg::word_w-1:0]     compare;
        logic                           count_tick;
        logic                           commit;
        logic [exc_pkg::word_w-1:0]     cause;

        assign commit = !stall;
        assign cause  = {cause_bd, timer_int, 14'd0, cause_ip_hw, cause_ip_sw,
                         1'b0, cause_code, 2'b00};

        ///////////////////////////////////////////////////////////////////////
        // Status, Cause, EPC, BadVAddr
        ///////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (reset) begin
                        status      <= exc_pkg::status_reset;
                        cause_bd    <= 1'b0;
                        cause_ip_hw <= '0;
                        cause_ip_sw <= '0;
                        cause_code  <= '0;
                end else if (commit) begin
                        cause_ip_hw <= ip_hw;
                        if (mtc0_wen && mtc0_addr == exc_pkg::cp0_status) begin
                                status[15:8] <= mtc0_data[15:8];  // IM
                                status[1:0]  <= mtc0_data[1:0];   // EXL, IE
                        end
                        if (mtc0_wen && mtc0_addr == exc_pkg::cp0_cause)
                                cause_ip_sw <= mtc0_data[9:8];
                        if (mtc0_wen && mtc0_addr == exc_pkg::cp0_epc)
                                epc <= mtc0_data;
                        // Exception and eret override a same-cycle mtc0
                        if (exp_en) begin
                                status[1]  <= 1'b1;
                                cause_bd   <= exp_bd;
                                cause_code <= exp_code;
                                epc        <= exp_epc;
                        end else if (exl_clean) begin
                                status[1] <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (commit && bad_vaddr_wen)
                        badvaddr <= bad_vaddr;
        end

        ///////////////////////////////////////////////////////////////////////
        // Count and Compare
        ///////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (reset) begin
                        count_tick <= 1'b0;
                        count      <= '0;
                        compare    <= '0;
                        timer_int  <= 1'b0;
                end else begin
                        count_tick <= ~count_tick;      // Count runs at half rate
                        if (commit && mtc0_wen && mtc0_addr == exc_pkg::cp0_count)
                                count <= mtc0_data;
                        else if (count_tick)
                                count <= count + 32'd1;
                        if (commit && mtc0_wen && mtc0_addr == exc_pkg::cp0_compare) begin
                                compare   <= mtc0_data;
                                timer_int <= 1'b0;      // Acknowledge
                        end else if (count == compare) begin
                                timer_int <= 1'b1;
                        end
                end
        end

        always_comb begin
                case (mfc0_addr)
                        exc_pkg::cp0_badvaddr: mfc0_data = badvaddr;
                        exc_pkg::cp0_count:    mfc0_data = count;
                        exc_pkg::cp0_compare:  mfc0_data = compare;
                        exc_pkg::cp0_status:   mfc0_data = status;
                        exc_pkg::cp0_cause:    mfc0_data = cause;
                        exc_pkg::cp0_epc:      mfc0_data = epc;
                        default:               mfc0_data = '0;
                endcase
        end

endmodule

// File: cp0/interrupt_ctrl.sv
`timescale 1ns/1ns
module interrupt_ctrl (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            stall,
        input  logic [5:0]                      hw_int,
        input  logic                            timer_int,
        input  logic [exc_pkg::word_w-1:0]      status,
        input  logic [1:0]                      cause_ip_sw,

        output logic [5:0]                      ip_hw,
        output logic                            int_pending
);

        logic [5:0]                     hw_sync;
        logic [exc_pkg::int_lines-1:0]  lines;
        logic [exc_pkg::int_lines-1:0]  unmasked;

        // One stage of sampling on the external lines
        always_ff @(posedge clk) begin
                if (reset)
                        hw_sync <= '0;
                else if (!stall)
                        hw_sync <= hw_int;
        end

        assign ip_hw = {hw_sync[5] | timer_int, hw_sync[4:0]};    // Timer on line 7
        assign lines = {ip_hw, cause_ip_sw};

        ///////////////////////////////////////////////////////////////////////
        // Masking with Status.IM, then IE and not EXL
        ///////////////////////////////////////////////////////////////////////
        assign unmasked    = lines & status[15:8];
        assign int_pending = (|unmasked) && status[0] && !status[1];

endmodule

// File: src/exception_unit.sv
`timescale 1ns/1ns
module exception_unit (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            stall,
        input  logic                            is_inst,
        input  logic                            is_branch,
        input  logic                            iaddr_misaligned,
        input  logic                            daddr_misaligned,
        input  logic                            mem_wen,
        input  logic                            invalid_inst,
        input  logic                            priv_inst,
        input  logic                            syscall,
        input  logic                            break_inst,
        input  logic                            eret,
        input  logic                            overflow,
        input  logic                            slave_invalid_inst,
        input  logic                            slave_overflow,
        input  logic [exc_pkg::word_w-1:0]      pc_address,
        input  logic [exc_pkg::word_w-1:0]      mem_address,
        input  logic [exc_pkg::word_w-1:0]      epc,
        input  logic                            int_pending,

        output logic                            exp_detect,
        output logic                            exp_en,
        output logic                            exl_clean,
        output logic [exc_pkg::exc_code_w-1:0]  exp_code,
        output logic [exc_pkg::word_w-1:0]      exp_epc,
        output logic                            exp_bd,
        output logic [exc_pkg::word_w-1:0]      bad_vaddr,
        output logic                            bad_vaddr_wen,
        output logic [exc_pkg::word_w-1:0]      exp_pc
);

        logic in_delay_slot;    // Previous committed instruction was a branch

        always_ff @(posedge clk) begin
                if (reset || (!stall && exp_detect))
                        in_delay_slot <= 1'b0;
                else if (!stall && is_inst)
                        in_delay_slot <= is_branch;
        end

        ///////////////////////////////////////////////////////////////////////
        // Priority chain, highest first
        ///////////////////////////////////////////////////////////////////////
        always_comb begin
                exp_detect    = 1'b1;
                exp_en        = 1'b1;
                exl_clean     = 1'b0;
                exp_code      = exc_pkg::exc_int;
                exp_bd        = in_delay_slot;
                exp_epc       = in_delay_slot ? pc_address - 32'd4 : pc_address;
                bad_vaddr     = pc_address;
                bad_vaddr_wen = 1'b0;
                exp_pc        = exc_pkg::exc_vector;

                if (is_inst && int_pending) begin
                        exp_code = exc_pkg::exc_int;
                end else if (iaddr_misaligned) begin
                        exp_code      = exc_pkg::exc_adel;
                        bad_vaddr_wen = 1'b1;
                end else if (syscall) begin
                        exp_code = exc_pkg::exc_sys;
                end else if (break_inst) begin
                        exp_code = exc_pkg::exc_bp;
                end else if (invalid_inst) begin
                        exp_code = exc_pkg::exc_ri;
                end else if (priv_inst) begin
                        exp_code = exc_pkg::exc_cpu;
                end else if (overflow) begin
                        exp_code = exc_pkg::exc_ov;
                end else if (eret) begin
                        exp_en    = 1'b0;       // Return, not a new exception
                        exl_clean = 1'b1;
                        exp_pc    = epc;
                end else if (daddr_misaligned) begin
                        exp_code      = mem_wen ? exc_pkg::exc_ades : exc_pkg::exc_adel;
                        bad_vaddr     = mem_address;
                        bad_vaddr_wen = 1'b1;
                end else if (slave_invalid_inst || slave_overflow) begin
                        // Slave sits in the master's delay slot when the master branches
                        exp_code = slave_invalid_inst ? exc_pkg::exc_ri : exc_pkg::exc_ov;
                        exp_bd   = is_branch;
                        exp_epc  = is_branch ? pc_address : pc_address + 32'd4;
                end else begin
                        exp_detect = 1'b0;
                        exp_en     = 1'b0;
                end
        end

endmodule

// File: src/exception_top.sv
`timescale 1ns/1ns
module exception_top (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            stall,
        input  logic                            is_inst,
        input  logic                            is_branch,
        input  logic                            iaddr_misaligned,
        input  logic                            daddr_misaligned,
        input  logic                            mem_wen,
        input  logic                            invalid_inst,
        input  logic                            priv_inst,
        input  logic                            syscall,
        input  logic                            break_inst,
        input  logic                            eret,
        input  logic                            overflow,
        input  logic                            slave_invalid_inst,
        input  logic                            slave_overflow,
        input  logic [exc_pkg::word_w-1:0]      pc_address,
        input  logic [exc_pkg::word_w-1:0]      mem_address,
        input  logic [5:0]                      hw_int,
        input  logic                            mtc0_wen,
        input  logic [4:0]                      mtc0_addr,
        input  logic [exc_pkg::word_w-1:0]      mtc0_data,
        input  logic [4:0]                      mfc0_addr,

        output logic                            exp_detect,
        output logic [exc_pkg::exc_code_w-1:0]  exp_code,
        output logic [exc_pkg::word_w-1:0]      exp_epc,
        output logic                            exp_bd,
        output logic [exc_pkg::word_w-1:0]      exp_bad_vaddr,
        output logic                            exp_bad_vaddr_wen,
        output logic [exc_pkg::word_w-1:0]      exp_pc,
        output logic [exc_pkg::word_w-1:0]      mfc0_data
);

        logic                           exp_en;
        logic                           exl_clean;
        logic                           int_pending;
        logic                           timer_int;
        logic [5:0]                     ip_hw;
        logic [1:0]                     cause_ip_sw;
        logic [exc_pkg::word_w-1:0]     epc;
        logic [exc_pkg::word_w-1:0]     status;

        exception_unit u_exception_unit (
                .clk, .reset, .stall, .is_inst, .is_branch,
                .iaddr_misaligned, .daddr_misaligned, .mem_wen,
                .invalid_inst, .priv_inst, .syscall, .break_inst, .eret, .overflow,
                .slave_invalid_inst, .slave_overflow,
                .pc_address, .mem_address, .epc, .int_pending,
                .exp_detect, .exp_en, .exl_clean, .exp_code, .exp_epc, .exp_bd,
                .bad_vaddr(exp_bad_vaddr), .bad_vaddr_wen(exp_bad_vaddr_wen), .exp_pc
        );

        cp0_regs u_cp0_regs (
                .clk, .reset, .stall, .mtc0_wen, .mtc0_addr, .mtc0_data, .mfc0_addr,
                .exp_en, .exl_clean, .exp_code, .exp_bd, .exp_epc,
                .bad_vaddr(exp_bad_vaddr), .bad_vaddr_wen(exp_bad_vaddr_wen), .ip_hw,
                .mfc0_data, .epc, .status, .cause_ip_sw, .timer_int
        );

        interrupt_ctrl u_interrupt_ctrl (
                .clk, .reset, .stall, .hw_int, .timer_int, .status, .cause_ip_sw,
                .ip_hw, .int_pending
        );

endmodule

// File: verification/tb_exception_top.sv
`timescale 1ns/1ns
module tb_exception_top;

        localparam int poll_limit = 200;        // Cycles allowed for the timer to fire
        localparam int line_limit = 1000;

        logic           clk;
        logic           reset;
        logic           stall;
        logic           is_inst;
        logic           is_branch;
        logic           iaddr_misaligned;
        logic           daddr_misaligned;
        logic           mem_wen;
        logic           invalid_inst;
        logic           priv_inst;
        logic           syscall;
        logic           break_inst;
        logic           eret;
        logic           overflow;
        logic           slave_invalid_inst;
        logic           slave_overflow;
        logic [31:0]    pc_address;
        logic [31:0]    mem_address;
        logic [5:0]     hw_int;
        logic           mtc0_wen;
        logic [4:0]     mtc0_addr;
        logic [31:0]    mtc0_data;
        logic [4:0]     mfc0_addr;

        logic           exp_detect;
        logic [4:0]     exp_code;
        logic [31:0]    exp_epc;
        logic           exp_bd;
        logic [31:0]    exp_bad_vaddr;
        logic           exp_bad_vaddr_wen;
        logic [31:0]    exp_pc;
        logic [31:0]    mfc0_data;

        int             checks = 0;
        int             value_errors = 0;
        int             other_errors = 0;

        exception_top UUT (.*);

        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        ///////////////////////////////////////////////////////////////////////
        // Stimulus and checking helpers
        ///////////////////////////////////////////////////////////////////////
        task automatic apply_inputs(input logic [31:0] flags, input logic [31:0] pc,
                                    input logic [31:0] addr, input logic [31:0] ctl,
                                    input logic [31:0] data, input logic write);
                iaddr_misaligned   = flags[0];
                daddr_misaligned   = flags[1];
                mem_wen            = flags[2];
                invalid_inst       = flags[3];
                priv_inst          = flags[4];
                syscall            = flags[5];
                break_inst         = flags[6];
                eret               = flags[7];
                overflow           = flags[8];
                slave_invalid_inst = flags[9];
                slave_overflow     = flags[10];
                pc_address         = pc;
                mem_address        = addr;
                is_branch          = ctl[0];
                is_inst            = ctl[1];
                stall              = ctl[2];
                hw_int             = ctl[13:8];
                mtc0_wen           = write;
                mtc0_data          = data;
        endtask

        task automatic check_word(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
                checks++;
                assert (actual === expected) else begin
                        $display("[FAIL] t=%0t %s expected %h got %h",
                                 $time, name, expected, actual);
                        value_errors++;
                end
        endtask

        task automatic check_outputs(input logic [31:0] want_det, input logic [31:0] want_code,
                                     input logic [31:0] want_epc, input logic [31:0] want_bd,
                                     input logic [31:0] want_pc, input logic [31:0] flags,
                                     input logic [31:0] pc, input logic [31:0] addr);
                logic addr_error;

                addr_error = (want_det != 32'd0) &&
                             (want_code == 32'h04 || want_code == 32'h05);
                check_word("exp_detect", 32'(exp_detect), want_det);
                check_word("exp_bad_vaddr_wen", 32'(exp_bad_vaddr_wen), 32'(addr_error));
                if (want_det != 32'd0) begin    // Commit fields only mean something on an event
                        check_word("exp_code", 32'(exp_code), want_code);
                        check_word("exp_epc", exp_epc, want_epc);
                        check_word("exp_bd", 32'(exp_bd), want_bd);
                        check_word("exp_pc", exp_pc, want_pc);
                end
                if (addr_error)         // Fetch faults report the PC, data faults the address
                        check_word("exp_bad_vaddr", exp_bad_vaddr, flags[0] ? pc : addr);
        endtask

        ///////////////////////////////////////////////////////////////////////
        // Pattern file runner
        ///////////////////////////////////////////////////////////////////////
        initial begin
                int                     fd;
                int                     n;
                int                     line_no;
                int                     polls;
                logic                   done;
                logic                   known;
                logic [31:0]            op_word;
                logic [8*256-1:0]       skip_line;
                logic [31:0]            flags, pc, addr, ctl, reg_field, data;
                logic [31:0]            want_det, want_code, want_epc, want_bd, want_pc;

                void'($urandom(32'h9301));
                line_no   = 0;
                done      = 1'b0;
                reset     = 1'b1;
                mtc0_addr = '0;
                mfc0_addr = '0;
                apply_inputs('0, '0, '0, '0, '0, 1'b0);
                repeat (16) @(posedge clk);
                #1;
                reset = 1'b0;

                fd = $fopen("verification/exc_patterns.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the pattern file verification/exc_patterns.txt");
                        other_errors++;
                        done = 1'b1;
                end
                while (!done) begin
                        op_word = '0;
                        n = $fscanf(fd, "%s", op_word);
                        if (n != 1 || line_no >= line_limit) begin
                                done = 1'b1;
                        end else if (op_word == {24'd0, "#"}) begin
                                n = $fgets(skip_line, fd);
                        end else begin
                                line_no++;
                                known = (op_word == "step") || (op_word == "rand") ||
                                        (op_word == "mtc0") || (op_word == "mfc0") ||
                                        (op_word == "wait");
                                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                                            flags, pc, addr, ctl, reg_field, data,
                                            want_det, want_code, want_epc, want_bd, want_pc);
                                if (!known || n != 11) begin
                                        $display("Pattern line %0d is malformed or has an unknown operation",
                                                 line_no);
                                        other_errors++;
                                        n = $fgets(skip_line, fd);
                                end else begin
                                        if (op_word == "rand")
                                                addr = $urandom() & addr;  // Mask picks the free bits
                                        mtc0_addr = reg_field[4:0];
                                        mfc0_addr = reg_field[4:0];
                                        apply_inputs(flags, pc, addr, ctl, data, op_word == "mtc0");
                                        #6;
                                        if (op_word == "wait") begin
                                                polls = 0;
                                                while ((mfc0_data & data) == 32'd0 && polls < poll_limit) begin
                                                        @(posedge clk);
                                                        #7;
                                                        polls++;
                                                end
                                                if ((mfc0_data & data) == 32'd0) begin
                                                        $display("Timed out on line %0d waiting for CP0 bits %h",
                                                                 line_no, data);
                                                        other_errors++;
                                                end
                                        end else begin
                                                check_outputs(want_det, want_code, want_epc,
                                                              want_bd, want_pc, flags, pc, addr);
                                                if (op_word == "mfc0")
                                                        check_word("mfc0_data", mfc0_data, data);
                                        end
                                        @(posedge clk);
                                        #1;
                                end
                        end
                end
                if (fd != 0)
                        $fclose(fd);

                $display("Lines %0d, checks %0d, value errors %0d, other errors %0d",
                         line_no, checks, value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("TEST PASS");
                end else begin
                        $display("TEST FAIL");
                end
                $finish;
        end

endmodule

// File: verification/exc_patterns.txt
# op flags pc addr ctl reg data | det code epc bd exp_pc  (all hex, data is the mfc0 result for mfc0)
# flags b0 iaddr b1 daddr b2 mem_wen b3 ri b4 cpu b5 sys b6 bp b7 eret b8 ov b9 slave_ri b10 slave_ov
# ctl b0 is_branch b1 is_inst b2 stall b13..8 hw_int, rand uses addr as a mask of free bits
mtc0 0   00000000 00000000 0   0b 7fffffff 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0c 00400000 0 00 00000000 0 00000000
step 168 80001000 00000000 2   00 00000000 1 08 80001000 0 bfc00380
step 0a1 80001002 00000000 2   00 00000000 1 04 80001002 0 bfc00380
step 118 80001008 00000000 2   00 00000000 1 0a 80001008 0 bfc00380
step 192 8000100c 00000000 2   00 00000000 1 0b 8000100c 0 bfc00380
step 180 80001010 00000000 2   00 00000000 1 0c 80001010 0 bfc00380
step 202 80001014 00002003 2   00 00000000 1 04 80001014 0 bfc00380
step 600 80001020 00000000 2   00 00000000 1 0a 80001024 0 bfc00380
rand 0   80001030 ffffffff 2   00 00000000 0 00 00000000 0 00000000
rand 0   80001034 0000fff0 0   00 00000000 0 00 00000000 0 00000000
step 0   80002000 00000000 3   00 00000000 0 00 00000000 0 00000000
step 100 80002004 00000000 2   00 00000000 1 0c 80002000 1 bfc00380
mfc0 0   00000000 00000000 0   0e 80002000 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0d 80000030 0 00 00000000 0 00000000
step 400 80003000 00000000 3   00 00000000 1 0c 80003000 1 bfc00380
mfc0 0   00000000 00000000 0   0e 80003000 0 00 00000000 0 00000000
step 006 80004000 10000006 2   00 00000000 1 05 80004000 0 bfc00380
mfc0 0   00000000 00000000 0   08 10000006 0 00 00000000 0 00000000
step 001 80004101 00000000 2   00 00000000 1 04 80004101 0 bfc00380
mfc0 0   00000000 00000000 0   08 80004101 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0c 00400002 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   0e 80005000 0 00 00000000 0 00000000
step 080 80006000 00000000 2   00 00000000 1 00 80006000 0 80005000
mfc0 0   00000000 00000000 0   0c 00400000 0 00 00000000 0 00000000
step 020 80007000 00000000 6   00 00000000 1 08 80007000 0 bfc00380
mtc0 0   00000000 00000000 4   0e 12345678 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0c 00400000 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0e 80005000 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   0c 00000101 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   0d 00000100 0 00 00000000 0 00000000
step 0   80008000 00000000 2   00 00000000 1 00 80008000 0 bfc00380
mfc0 0   00000000 00000000 0   0d 00000100 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   0d 00000000 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   0c 00000401 0 00 00000000 0 00000000
step 0   00000000 00000000 100 00 00000000 0 00 00000000 0 00000000
step 0   00000000 00000000 100 00 00000000 0 00 00000000 0 00000000
step 0   80009000 00000000 102 00 00000000 1 00 80009000 0 bfc00380
mtc0 0   00000000 00000000 100 0c 00000801 0 00 00000000 0 00000000
step 0   8000a000 00000000 102 00 00000000 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0d 00000400 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   0c 00008001 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   09 00000000 0 00 00000000 0 00000000
mtc0 0   00000000 00000000 0   0b 00000010 0 00 00000000 0 00000000
wait 0   00000000 00000000 0   0d 40000000 0 00 00000000 0 00000000
step 0   8000b000 00000000 2   00 00000000 1 00 8000b000 0 bfc00380
mtc0 0   00000000 00000000 0   0b 7fffffff 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0d 00008000 0 00 00000000 0 00000000
mfc0 0   00000000 00000000 0   0d 00000000 0 00 00000000 0 00000000

// File: sim.f
common/exc_pkg.sv
cp0/cp0_regs.sv
cp0/interrupt_ctrl.sv
src/exception_unit.sv
src/exception_top.sv
verification/tb_exception_top.sv

// File: Makefile
# Verilator build and run for the exception and CP0 testbench

VERILATOR ?= verilator
TOP       ?= tb_exception_top
FLAGS     ?= -j 0

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, pass on TEST PASS"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR, TOP, FLAGS"

test:
	$(VERILATOR) --binary --assert --top-module $(TOP) $(FLAGS) -f sim.f
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
